//--- mem_pkg.sv
// Memory stage shared definitions

package mem_pkg;

        // ------------------------------
        // Widths
        // ------------------------------

        localparam int DATA_WDT = 32;                   // Data and address width.

        // ------------------------------
        // Load size encoding
        // ------------------------------

        typedef enum logic [2:0] {
                LS_WORD  = 3'd0,                        // Rotated 32-bit word.
                LS_UBYTE = 3'd1,                        // Zero extended byte.
                LS_SBYTE = 3'd2,                        // Sign extended byte.
                LS_UHALF = 3'd3,                        // Zero extended halfword.
                LS_SHALF = 3'd4                         // Sign extended halfword.
        } load_size_t;

        // ------------------------------
        // Exception kinds, highest priority first
        // ------------------------------

        typedef enum logic [2:0] {
                EXC_NONE           = 3'd0,              // Normal retire.
                EXC_DATA_ABORT     = 3'd1,              // Bus error on data access.
                EXC_FIQ            = 3'd2,              // Fast interrupt.
                EXC_IRQ            = 3'd3,              // Normal interrupt.
                EXC_PREFETCH_ABORT = 3'd4,              // Instruction fetch abort.
                EXC_UNDEF          = 3'd5,              // Undefined instruction.
                EXC_SWI            = 3'd6               // Software interrupt.
        } exc_kind_t;

endpackage

//--- postalu_reg.sv
// Post-ALU pipeline register

`timescale 1ns/1ps

module postalu_reg
        import mem_pkg::*;
#(
        parameter int PHY_REGS = 46,                            // Physical registers.
        parameter int FLAG_WDT = 32                             // Flag word width.
)
(
        input  logic                            i_clk,          // Clock.
        input  logic                            i_reset,        // Sync reset.
        input  logic                            i_clear_from_writeback, // Pipeline flush.

        input  logic                            i_dav,          // Record valid.
        input  logic [DATA_WDT-1:0]             i_alu_result,   // ALU result.
        input  logic [FLAG_WDT-1:0]             i_flags,        // Flag word.
        input  logic [$clog2(PHY_REGS)-1:0]     i_dest_index,   // ALU destination.
        input  logic                            i_abt,          // Prefetch abort flagged.
        input  logic                            i_irq,          // IRQ flagged.
        input  logic                            i_fiq,          // FIQ flagged.
        input  logic                            i_swi,          // SWI flagged.
        input  logic                            i_und,          // Undefined flagged.
        input  logic [DATA_WDT-1:0]             i_pc_plus_8,    // PC + 8.
        input  logic [$clog2(PHY_REGS)-1:0]     i_mem_index,    // Load destination.
        input  logic                            i_mem_load,     // Load indicator.
        input  load_size_t                      i_mem_size,     // Load size.
        input  logic [DATA_WDT-1:0]             i_mem_address,  // Access address.
        input  logic                            i_mem_translate,// User view of memory.
        input  logic                            i_bus_we,       // Store.
        input  logic                            i_bus_cyc,      // Access requested.
        input  logic [DATA_WDT-1:0]             i_bus_dat,      // Store data.
        input  logic [DATA_WDT/8-1:0]           i_bus_sel,      // Byte selects.
        input  logic                            i_bus_ack,      // Bus acknowledge.
        input  logic                            i_bus_err,      // Bus error, with ack.

        output logic                            o_stall,        // Open cycle, no ack.
        output logic                            o_dav,
        output logic [DATA_WDT-1:0]             o_alu_result,
        output logic [FLAG_WDT-1:0]             o_flags,
        output logic [$clog2(PHY_REGS)-1:0]     o_dest_index,
        output logic                            o_abt,
        output logic                            o_irq,
        output logic                            o_fiq,
        output logic                            o_swi,
        output logic                            o_und,
        output logic [DATA_WDT-1:0]             o_pc_plus_8,
        output logic [$clog2(PHY_REGS)-1:0]     o_mem_index,
        output logic                            o_mem_load,
        output load_size_t                      o_mem_size,
        output logic [DATA_WDT-1:0]             o_mem_address,
        output logic                            o_mem_translate,// Carried only.
        output logic                            o_bus_cyc,
        output logic                            o_bus_stb,
        output logic                            o_bus_we,
        output logic [DATA_WDT-1:0]             o_bus_adr,
        output logic [DATA_WDT-1:0]             o_bus_dat,
        output logic [DATA_WDT/8-1:0]           o_bus_sel
);

logic sleep_ff;                                         // Set after a data fault.
logic fault;                                            // Ack with error.
logic take;                                             // Incoming record kept.

assign o_stall   = o_bus_cyc & ~i_bus_ack;              // Hold until ack.
assign fault     = o_bus_cyc & i_bus_ack & i_bus_err;   // Data abort.
assign take      = ~sleep_ff & ~fault;                  // Discard after fault.
assign o_bus_adr = o_mem_address;                       // Address from held record.

// ------------------------------
// Control and flag state
// ------------------------------

always_ff @(posedge i_clk)
begin
        if (i_reset || i_clear_from_writeback)          // Flush wins over all.
        begin
                sleep_ff   <= 1'b0;
                o_dav      <= 1'b0;
                o_bus_cyc  <= 1'b0;
                o_bus_stb  <= 1'b0;
                o_mem_load <= 1'b0;
                o_flags    <= '0;
                o_abt      <= 1'b0;
                o_irq      <= 1'b0;
                o_fiq      <= 1'b0;
                o_swi      <= 1'b0;
                o_und      <= 1'b0;
        end
        else if (!o_stall)
        begin
                sleep_ff   <= sleep_ff | fault;         // Sticky until clear.
                o_dav      <= take & i_dav;
                o_bus_cyc  <= take & i_bus_cyc;         // Opens a bus cycle.
                o_bus_stb  <= take & i_bus_cyc;
                o_mem_load <= take & i_mem_load;
                o_flags    <= take ? i_flags : '0;      // Blanked while asleep.
                o_abt      <= take & i_abt;
                o_irq      <= take & i_irq;
                o_fiq      <= take & i_fiq;
                o_swi      <= take & i_swi;
                o_und      <= take & i_und;
        end
end

// ------------------------------
// Payload, frozen during a cycle
// ------------------------------

always_ff @(posedge i_clk)
begin
        if (!o_stall)
        begin
                o_alu_result    <= i_alu_result;
                o_dest_index    <= i_dest_index;
                o_pc_plus_8     <= i_pc_plus_8;
                o_mem_index     <= i_mem_index;
                o_mem_size      <= i_mem_size;
                o_mem_address   <= i_mem_address;       // Stable bus address.
                o_mem_translate <= i_mem_translate;
                o_bus_we        <= i_bus_we;
                o_bus_dat       <= i_bus_dat;
                o_bus_sel       <= i_bus_sel;
        end
end

endmodule

//--- load_align.sv
// Load data alignment

`timescale 1ns/1ps

module load_align
        import mem_pkg::*;
(
        input  logic [DATA_WDT-1:0]     i_rdat,         // Bus read data.
        input  load_size_t              i_size,         // Load size.
        input  logic [1:0]              i_addr_lo,      // Byte offset.
        output logic [DATA_WDT-1:0]     o_load_data     // Aligned result.
);

logic [2*DATA_WDT-1:0]  rot_dbl;                        // Doubled word for rotate.
logic [DATA_WDT-1:0]    rot_word;                       // Rotated right word.
logic [7:0]             byte_lane;                      // Addressed byte.
logic [15:0]            half_lane;                      // Addressed halfword.

always_comb
begin
        rot_dbl   = {i_rdat, i_rdat} >> {i_addr_lo, 3'd0}; // Rotate by 8 * offset.
        rot_word  = rot_dbl[DATA_WDT-1:0];
        byte_lane = rot_word[7:0];                      // Lane lands at bottom.
        half_lane = i_addr_lo[1] ? i_rdat[31:16] : i_rdat[15:0];

        case (i_size)
        LS_UBYTE: o_load_data = {{(DATA_WDT-8){1'b0}}, byte_lane};
        LS_SBYTE: o_load_data = {{(DATA_WDT-8){byte_lane[7]}}, byte_lane};
        LS_UHALF: o_load_data = {{(DATA_WDT-16){1'b0}}, half_lane};
        LS_SHALF: o_load_data = {{(DATA_WDT-16){half_lane[15]}}, half_lane};
        default:  o_load_data = rot_word;               // Word load.
        endcase
end

endmodule

//--- exception_select.sv
// Exception priority encoder

`timescale 1ns/1ps

module exception_select
        import mem_pkg::*;
(
        input  logic            i_dav,          // Record valid.
        input  logic            i_fault,        // Data bus error.
        input  logic            i_abt,          // Prefetch abort.
        input  logic            i_irq,          // IRQ.
        input  logic            i_fiq,          // FIQ.
        input  logic            i_swi,          // SWI.
        input  logic            i_und,          // Undefined.
        output exc_kind_t       o_exc_kind      // Highest pending kind.
);

always_comb
begin
        if (!i_dav)
                o_exc_kind = EXC_NONE;                  // Bubble.
        else if (i_fault)
                o_exc_kind = EXC_DATA_ABORT;
        else if (i_fiq)
                o_exc_kind = EXC_FIQ;
        else if (i_irq)
                o_exc_kind = EXC_IRQ;
        else if (i_abt)
                o_exc_kind = EXC_PREFETCH_ABORT;
        else if (i_und)
                o_exc_kind = EXC_UNDEF;
        else if (i_swi)
                o_exc_kind = EXC_SWI;
        else
                o_exc_kind = EXC_NONE;
end

endmodule

//--- writeback_combine.sv
// Retire record register

`timescale 1ns/1ps

module writeback_combine
        import mem_pkg::*;
#(
        parameter int PHY_REGS = 46,                            // Physical registers.
        parameter int FLAG_WDT = 32                             // Flag word width.
)
(
        input  logic                            i_clk,          // Clock.
        input  logic                            i_reset,        // Sync reset.
        input  logic                            i_clear_from_writeback, // Flush.
        input  logic                            i_stall,        // Bus cycle open.
        input  logic                            i_dav,          // Record valid.
        input  logic                            i_mem_load,     // Load record.
        input  logic [DATA_WDT-1:0]             i_alu_result,   // ALU result.
        input  logic [DATA_WDT-1:0]             i_load_data,    // Aligned load data.
        input  logic [$clog2(PHY_REGS)-1:0]     i_dest_index,   // ALU destination.
        input  logic [$clog2(PHY_REGS)-1:0]     i_mem_index,    // Load destination.
        input  logic [FLAG_WDT-1:0]             i_flags,        // Flag word.
        input  logic [DATA_WDT-1:0]             i_pc_plus_8,    // PC + 8.
        input  exc_kind_t                       i_exc_kind,     // Ranked exception.

        output logic                            o_wb_valid,
        output logic [$clog2(PHY_REGS)-1:0]     o_wb_index,
        output logic [DATA_WDT-1:0]             o_wb_data,
        output logic [FLAG_WDT-1:0]             o_wb_flags,
        output logic [DATA_WDT-1:0]             o_wb_pc,
        output exc_kind_t                       o_wb_exc
);

logic use_load;                                         // Good load result.

assign use_load = i_mem_load & (i_exc_kind != EXC_DATA_ABORT);

// ------------------------------
// Control
// ------------------------------

always_ff @(posedge i_clk)
begin
        if (i_reset || i_clear_from_writeback)
        begin
                o_wb_valid <= 1'b0;
                o_wb_exc   <= EXC_NONE;
        end
        else if (!i_stall)
        begin
                o_wb_valid <= i_dav;
                o_wb_exc   <= i_exc_kind;
        end
end

// Payload follows the same enable.
always_ff @(posedge i_clk)
begin
        if (!i_stall)
        begin
                o_wb_index <= use_load ? i_mem_index : i_dest_index;
                o_wb_data  <= use_load ? i_load_data : i_alu_result;
                o_wb_flags <= i_flags;
                o_wb_pc    <= i_pc_plus_8;              // Always PC + 8.
        end
end

endmodule

//--- mem_stage_top.sv
// Memory access and retire stage

`timescale 1ns/1ps

module mem_stage_top
        import mem_pkg::*;
#(
        parameter int PHY_REGS = 46,                            // Physical registers.
        parameter int FLAG_WDT = 32                             // Flag word width.
)
(
        input  logic                            i_clk,
        input  logic                            i_reset,
        input  logic                            i_clear_from_writeback,

        // ALU-side record.
        input  logic                            i_dav,
        input  logic [DATA_WDT-1:0]             i_alu_result,
        input  logic [FLAG_WDT-1:0]             i_flags,
        input  logic [$clog2(PHY_REGS)-1:0]     i_dest_index,
        input  logic                            i_abt,
        input  logic                            i_irq,
        input  logic                            i_fiq,
        input  logic                            i_swi,
        input  logic                            i_und,
        input  logic [DATA_WDT-1:0]             i_pc_plus_8,
        input  logic [$clog2(PHY_REGS)-1:0]     i_mem_index,
        input  logic                            i_mem_load,
        input  load_size_t                      i_mem_size,
        input  logic [DATA_WDT-1:0]             i_mem_address,
        input  logic                            i_mem_translate,
        input  logic                            i_bus_we,
        input  logic                            i_bus_cyc,
        input  logic [DATA_WDT-1:0]             i_bus_dat,
        input  logic [DATA_WDT/8-1:0]           i_bus_sel,

        // Data bus.
        input  logic                            i_bus_ack,
        input  logic                            i_bus_err,
        input  logic [DATA_WDT-1:0]             i_bus_rdat,
        output logic                            o_bus_cyc,
        output logic                            o_bus_stb,
        output logic                            o_bus_we,
        output logic [DATA_WDT-1:0]             o_bus_adr,
        output logic [DATA_WDT-1:0]             o_bus_dat,
        output logic [DATA_WDT/8-1:0]           o_bus_sel,
        output logic                            o_stall,        // Back-pressure.
        output logic                            o_mem_translate,// Carried translate bit.

        // Retire record.
        output logic                            o_wb_valid,
        output logic [$clog2(PHY_REGS)-1:0]     o_wb_index,
        output logic [DATA_WDT-1:0]             o_wb_data,
        output logic [FLAG_WDT-1:0]             o_wb_flags,
        output logic [DATA_WDT-1:0]             o_wb_pc,
        output exc_kind_t                       o_wb_exc
);

logic                           dav, abt, irq, fiq, swi, und, mem_load;
logic [DATA_WDT-1:0]            alu_result, pc_plus_8, mem_address, load_data;
logic [FLAG_WDT-1:0]            flags;
logic [$clog2(PHY_REGS)-1:0]    dest_index, mem_index;
load_size_t                     mem_size;
exc_kind_t                      exc_kind;

postalu_reg #(.PHY_REGS(PHY_REGS), .FLAG_WDT(FLAG_WDT)) u_postalu_reg (
        .i_clk(i_clk), .i_reset(i_reset), .i_clear_from_writeback(i_clear_from_writeback),
        .i_dav(i_dav), .i_alu_result(i_alu_result), .i_flags(i_flags),
        .i_dest_index(i_dest_index), .i_abt(i_abt), .i_irq(i_irq), .i_fiq(i_fiq),
        .i_swi(i_swi), .i_und(i_und), .i_pc_plus_8(i_pc_plus_8),
        .i_mem_index(i_mem_index), .i_mem_load(i_mem_load), .i_mem_size(i_mem_size),
        .i_mem_address(i_mem_address), .i_mem_translate(i_mem_translate),
        .i_bus_we(i_bus_we), .i_bus_cyc(i_bus_cyc), .i_bus_dat(i_bus_dat),
        .i_bus_sel(i_bus_sel), .i_bus_ack(i_bus_ack), .i_bus_err(i_bus_err),
        .o_stall(o_stall), .o_dav(dav), .o_alu_result(alu_result), .o_flags(flags),
        .o_dest_index(dest_index), .o_abt(abt), .o_irq(irq), .o_fiq(fiq),
        .o_swi(swi), .o_und(und), .o_pc_plus_8(pc_plus_8), .o_mem_index(mem_index),
        .o_mem_load(mem_load), .o_mem_size(mem_size), .o_mem_address(mem_address),
        .o_mem_translate(o_mem_translate), .o_bus_cyc(o_bus_cyc), .o_bus_stb(o_bus_stb),
        .o_bus_we(o_bus_we), .o_bus_adr(o_bus_adr), .o_bus_dat(o_bus_dat),
        .o_bus_sel(o_bus_sel)
);

load_align u_load_align (
        .i_rdat(i_bus_rdat), .i_size(mem_size), .i_addr_lo(mem_address[1:0]),
        .o_load_data(load_data)
);

// Fault is only meaningful on the ack of an open cycle.
exception_select u_exception_select (
        .i_dav(dav), .i_fault(o_bus_cyc & i_bus_ack & i_bus_err),
        .i_abt(abt), .i_irq(irq), .i_fiq(fiq), .i_swi(swi), .i_und(und),
        .o_exc_kind(exc_kind)
);

writeback_combine #(.PHY_REGS(PHY_REGS), .FLAG_WDT(FLAG_WDT)) u_writeback_combine (
        .i_clk(i_clk), .i_reset(i_reset), .i_clear_from_writeback(i_clear_from_writeback),
        .i_stall(o_stall), .i_dav(dav), .i_mem_load(mem_load),
        .i_alu_result(alu_result), .i_load_data(load_data), .i_dest_index(dest_index),
        .i_mem_index(mem_index), .i_flags(flags), .i_pc_plus_8(pc_plus_8),
        .i_exc_kind(exc_kind), .o_wb_valid(o_wb_valid), .o_wb_index(o_wb_index),
        .o_wb_data(o_wb_data), .o_wb_flags(o_wb_flags), .o_wb_pc(o_wb_pc),
        .o_wb_exc(o_wb_exc)
);

endmodule

//--- tb_mem_stage.sv
// Memory stage testbench

`timescale 1ns/1ps

module tb_mem_stage
        import mem_pkg::*;
;

localparam int PHY_REGS    = 46;                        // Physical registers.
localparam int FLAG_WDT    = 32;                        // Flag word width.
localparam int IDX_WDT     = $clog2(PHY_REGS);          // Index width.
localparam int SEED        = 5329;                      // Random seed.
localparam int STALL_LIMIT = 20;                        // Cycles before timeout.

logic                   i_clk = 1'b0;
logic                   i_reset, i_clear_from_writeback;
logic                   i_dav, i_abt, i_irq, i_fiq, i_swi, i_und;
logic [DATA_WDT-1:0]    i_alu_result, i_pc_plus_8, i_mem_address, i_bus_dat, i_bus_rdat;
logic [FLAG_WDT-1:0]    i_flags;
logic [IDX_WDT-1:0]     i_dest_index, i_mem_index;
logic                   i_mem_load, i_mem_translate, i_bus_we, i_bus_cyc;
load_size_t             i_mem_size;
logic [DATA_WDT/8-1:0]  i_bus_sel;
logic                   i_bus_ack, i_bus_err;
logic                   o_bus_cyc, o_bus_stb, o_bus_we, o_stall, o_mem_translate;
logic [DATA_WDT-1:0]    o_bus_adr, o_bus_dat, o_wb_data, o_wb_pc;
logic [DATA_WDT/8-1:0]  o_bus_sel;
logic                   o_wb_valid;
logic [IDX_WDT-1:0]     o_wb_index;
logic [FLAG_WDT-1:0]    o_wb_flags;
exc_kind_t              o_wb_exc;

// One trace row.
logic                   tr_clr, tr_dav, tr_cyc, tr_we, tr_load, tr_err, tr_valid;
logic [2:0]             tr_size, tr_wexc;
logic [4:0]             tr_fl;                          // abt irq fiq swi und.
logic [IDX_WDT-1:0]     tr_dest, tr_midx, tr_widx;
logic [31:0]            tr_addr, tr_rdat, tr_alu, tr_flags, tr_pc, tr_wdata;

logic [DATA_WDT-1:0]    store_dat;                      // Random store payload.
logic [DATA_WDT/8-1:0]  store_sel;
logic                   translate;
logic                   asleep;                         // Fault seen, no clear yet.
int                     fd, n, fields, rows;
string                  line;

mem_stage_top #(.PHY_REGS(PHY_REGS), .FLAG_WDT(FLAG_WDT)) UUT (.*);

always #50 i_clk = ~i_clk;                              // 100 ns period.

// ------------------------------
// Reporting
// ------------------------------

task stop_run();
        $display("Test failed");
        $fatal(1, "simulation stopped");
endtask

task check_value(input logic [31:0] actual, input logic [31:0] expected, input string what);
        if (actual !== expected)
        begin
                $display("[FAIL] %0t ns %s: got %h, expected %h", $time, what, actual, expected);
                stop_run();
        end
endtask

// ------------------------------
// Stimulus
// ------------------------------

task drive_record();
        i_dav           = tr_dav;
        i_alu_result    = tr_alu;
        i_flags         = tr_flags;
        i_dest_index    = tr_dest;
        {i_abt, i_irq, i_fiq, i_swi, i_und} = tr_fl;
        i_pc_plus_8     = tr_pc;
        i_mem_index     = tr_midx;
        i_mem_load      = tr_load;
        i_mem_size      = load_size_t'(tr_size);
        i_mem_address   = tr_addr;
        i_mem_translate = translate;
        i_bus_we        = tr_we;
        i_bus_cyc       = tr_cyc;
        i_bus_dat       = store_dat;
        i_bus_sel       = store_sel;
endtask

task drive_bubble();
        i_dav           = 1'b0;                         // Fresh payload, held while stalled.
        i_mem_load      = 1'b0;
        i_bus_cyc       = 1'b0;
        i_bus_we        = 1'b0;
        {i_abt, i_irq, i_fiq, i_swi, i_und} = 5'b0;
        i_alu_result    = $urandom;
        i_flags         = $urandom;
        i_dest_index    = IDX_WDT'($urandom);
        i_pc_plus_8     = $urandom;
        i_mem_index     = IDX_WDT'($urandom);
        i_mem_size      = load_size_t'(3'($urandom % 5));
        i_mem_address   = $urandom;
        i_mem_translate = 1'($urandom);
        i_bus_dat       = $urandom;
        i_bus_sel       = 4'($urandom);
endtask

// Open cycle must keep every bus field frozen.
task check_bus_hold();
        check_value(32'(o_stall), 32'd1, "stall during open cycle");
        check_value(32'(o_wb_valid), 32'd0, "no retire while stalled");
        check_value(32'(o_bus_stb), 32'd1, "bus strobe");
        check_value(32'(o_bus_we), 32'(tr_we), "bus write enable");
        check_value(o_bus_adr, tr_addr, "bus address");
        check_value(o_bus_dat, store_dat, "bus write data");
        check_value(32'(o_bus_sel), 32'(store_sel), "bus byte selects");
endtask

task wait_stall_low();
        int cycles;
        cycles = 0;
        #1;                                             // Let ack settle.
        while (o_stall)
        begin
                if (cycles >= STALL_LIMIT)
                begin
                        $display("Timeout: o_stall stayed high for %0d cycles", cycles);
                        stop_run();
                end
                else
                begin
                        @(negedge i_clk);
                        #1;
                        cycles++;
                end
        end
endtask

task check_retire();
        check_value(32'(o_wb_valid), 32'(tr_valid), "retire valid");
        if (tr_valid)
        begin
                check_value(32'(o_wb_index), 32'(tr_widx), "retire index");
                check_value(o_wb_data, tr_wdata, "retire data");
                check_value(32'(o_wb_exc), 32'(tr_wexc), "exception kind");
                check_value(o_wb_flags, tr_flags, "retire flags");
                check_value(o_wb_pc, tr_pc, "retire pc");
        end
endtask

// One record through the stage, bubble behind it.
task run_row();
        logic open;
        int   delay;
        if (tr_clr)
        begin
                i_clear_from_writeback = 1'b1;
                @(posedge i_clk);
                @(negedge i_clk);
                i_clear_from_writeback = 1'b0;
                asleep = 1'b0;                          // Clear wakes the stage.
        end
        store_dat = $urandom;
        store_sel = 4'($urandom);
        translate = 1'($urandom);
        drive_record();
        @(posedge i_clk);                               // Accepted here.
        @(negedge i_clk);
        drive_bubble();
        open = tr_cyc & ~asleep;                        // Asleep drops the access.
        check_value(32'(o_bus_cyc), 32'(open), "bus cycle opened");
        check_value(32'(o_mem_translate), 32'(translate), "translate bit carried");
        if (open)
        begin
                delay = $urandom % 4;                   // 0 to 3 wait cycles.
                repeat (delay)
                begin
                        check_bus_hold();
                        @(posedge i_clk);
                        @(negedge i_clk);
                end
                check_bus_hold();
                i_bus_ack  = 1'b1;
                i_bus_err  = tr_err;
                i_bus_rdat = tr_rdat;
        end
        wait_stall_low();
        @(posedge i_clk);                               // Retire edge.
        @(negedge i_clk);
        i_bus_ack  = 1'b0;
        i_bus_err  = 1'b0;
        i_bus_rdat = $urandom;                          // Garbage outside ack.
        if (open && tr_err)
                asleep = 1'b1;
        check_retire();
        check_value(32'(o_bus_cyc), 32'd0, "bus cycle closed");
        @(posedge i_clk);
        @(negedge i_clk);
        check_value(32'(o_wb_valid), 32'd0, "single retire per record");
endtask

// ------------------------------
// Main sequence
// ------------------------------

initial
begin
        void'($urandom(SEED));
        i_reset = 1'b1;
        i_clear_from_writeback = 1'b0;
        drive_bubble();
        i_bus_ack  = 1'b0;
        i_bus_err  = 1'b0;
        i_bus_rdat = '0;
        asleep     = 1'b0;
        rows       = 0;
        repeat (2) @(posedge i_clk);                    // Two reset cycles.
        @(negedge i_clk);
        i_reset = 1'b0;
        check_value(32'(o_wb_valid), 32'd0, "valid after reset");
        check_value(32'(o_bus_cyc), 32'd0, "bus cycle after reset");
        check_value(32'(o_stall), 32'd0, "stall after reset");
        check_value(32'(o_wb_exc), 32'(EXC_NONE), "exception after reset");
        fd = $fopen("mem_trace.txt", "r");
        if (fd == 0)
        begin
                $display("Could not open the trace file mem_trace.txt");
                stop_run();
        end
        n = $fgets(line, fd);
        while (n != 0)
        begin
                if (line.len() > 1 && line[0] != "#")
                begin
                        fields = $sscanf(line,
                                "%d %d %d %d %d %d %h %h %d %b %d %d %h %h %h %d %d %h %d",
                                tr_clr, tr_dav, tr_cyc, tr_we, tr_load, tr_size, tr_addr,
                                tr_rdat, tr_err, tr_fl, tr_dest, tr_midx, tr_alu, tr_flags,
                                tr_pc, tr_valid, tr_widx, tr_wdata, tr_wexc);
                        if (fields != 19)
                        begin
                                $display("Malformed trace line: %s", line);
                                stop_run();
                        end
                        run_row();
                        rows++;
                end
                n = $fgets(line, fd);
        end
        $fclose(fd);
        if (rows == 0)
        begin
                $display("The trace file holds no records");
                stop_run();
        end
        else
        begin
                $display("Test completed successfully");
                $finish;
        end
end

endmodule

//--- mem_trace.txt
# clr dav cyc we load size(0 word 1 ubyte 2 sbyte 3 uhalf 4 shalf) addr rdat err
# fl(abt irq fiq swi und) dest midx alu flags pc, then expected: valid index data exc
0 1 0 0 0 0 0000 00000000 0 00000 5 0 0000002a 0001 108 1 5 0000002a 0
0 1 0 0 0 0 0000 00000000 0 00000 45 0 deadbeef f00d 10c 1 45 deadbeef 0
0 0 0 0 0 0 0000 00000000 0 00000 7 0 12345678 0000 110 0 0 00000000 0
0 1 1 0 1 0 2000 8796a5c3 0 00000 3 10 00000000 0002 114 1 10 8796a5c3 0
0 1 1 0 1 0 2001 8796a5c3 0 00000 3 11 00000000 0002 118 1 11 c38796a5 0
0 1 1 0 1 0 2002 8796a5c3 0 00000 3 12 00000000 0002 11c 1 12 a5c38796 0
0 1 1 0 1 0 2003 8796a5c3 0 00000 3 13 00000000 0002 120 1 13 96a5c387 0
0 1 1 0 1 1 2000 8796a5c3 0 00000 3 14 00000000 0003 124 1 14 000000c3 0
0 1 1 0 1 1 2001 8796a5c3 0 00000 3 15 00000000 0003 128 1 15 000000a5 0
0 1 1 0 1 1 2002 8796a5c3 0 00000 3 16 00000000 0003 12c 1 16 00000096 0
0 1 1 0 1 1 2003 8796a5c3 0 00000 3 17 00000000 0003 130 1 17 00000087 0
0 1 1 0 1 2 2000 8796a5c3 0 00000 3 18 00000000 0003 134 1 18 ffffffc3 0
0 1 1 0 1 2 2003 8796a5c3 0 00000 3 19 00000000 0003 138 1 19 ffffff87 0
0 1 1 0 1 2 2001 7f3e015a 0 00000 3 20 00000000 0003 13c 1 20 00000001 0
0 1 1 0 1 2 2003 7f3e015a 0 00000 3 21 00000000 0003 140 1 21 0000007f 0
0 1 1 0 1 3 2000 8796a5c3 0 00000 3 22 00000000 0004 144 1 22 0000a5c3 0
0 1 1 0 1 3 2002 8796a5c3 0 00000 3 23 00000000 0004 148 1 23 00008796 0
0 1 1 0 1 3 2003 7f3e015a 0 00000 3 24 00000000 0004 14c 1 24 00007f3e 0
0 1 1 0 1 4 2001 8796a5c3 0 00000 3 25 00000000 0004 150 1 25 ffffa5c3 0
0 1 1 0 1 4 2002 8796a5c3 0 00000 3 26 00000000 0004 154 1 26 ffff8796 0
0 1 1 0 1 4 2002 7f3e015a 0 00000 3 27 00000000 0004 158 1 27 00007f3e 0
0 1 1 1 0 0 3004 00000000 0 00000 8 0 00000300 0005 15c 1 8 00000300 0
0 1 0 0 0 0 0000 00000000 0 00010 9 0 00000011 0010 160 1 9 00000011 6
0 1 0 0 0 0 0000 00000000 0 00001 9 0 00000012 0010 164 1 9 00000012 5
0 1 0 0 0 0 0000 00000000 0 00011 9 0 00000013 0010 168 1 9 00000013 5
0 1 0 0 0 0 0000 00000000 0 10011 9 0 00000014 0010 16c 1 9 00000014 4
0 1 0 0 0 0 0000 00000000 0 01001 9 0 00000015 0010 170 1 9 00000015 3
0 1 0 0 0 0 0000 00000000 0 11111 9 0 00000016 0010 174 1 9 00000016 2
0 1 1 0 1 0 2000 8796a5c3 0 00100 28 30 00000017 0020 178 1 30 8796a5c3 2
0 1 1 0 1 0 2004 8796a5c3 1 00100 31 32 00000abc 0040 17c 1 31 00000abc 1
0 1 0 0 0 0 0000 00000000 0 00000 33 0 00000001 0080 180 0 0 00000000 0
0 1 1 0 1 0 2008 8796a5c3 0 00000 33 34 00000000 0080 184 0 0 00000000 0
1 1 0 0 0 0 0000 00000000 0 00000 34 0 00000077 0100 188 1 34 00000077 0
0 1 1 0 1 1 2000 7f3e015a 0 00000 3 35 00000000 0200 18c 1 35 0000005a 0

//--- verilog.f
mem_pkg.sv
postalu_reg.sv
load_align.sv
exception_select.sv
writeback_combine.sv
mem_stage_top.sv
tb_mem_stage.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the memory stage testbench with Verilator and run it from the project root.
# A $fatal in the testbench gives a non-zero exit status.

cd "$(dirname "$0")" &&
verilator --binary --timing -sv -f verilog.f --top-module tb_mem_stage -o sim_mem_stage &&
./obj_dir/sim_mem_stage &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }
